//--- verif/instr_queue_assert.sv
`timescale 1ns/100ps
`default_nettype none

module instr_queue_assert (
    input wire clk,
    input wire rst,
    input wire rob_full,
    input wire iq_full,
    input wire push,
    input wire pop,
    input wire issued,
    input wire issue_valid
);

    // occupancy only climbs to the full level through a push that no pop cancels
    full_rises_on_push: assert property (@(posedge clk) disable iff (!rst)
        $rose(iq_full) |-> $past(push && !pop))
        else $error("iq_full rose without a lone push in the cycle before");

    full_falls_on_pop: assert property (@(posedge clk) disable iff (!rst)
        $fell(iq_full) |-> $past(pop && !push))
        else $error("iq_full fell without a lone pop in the cycle before");

    issued_after_pop: assert property (@(posedge clk) disable iff (!rst)
        pop |=> issued)
        else $error("issued did not follow a pop");

    issued_needs_pop: assert property (@(posedge clk) disable iff (!rst)
        issued |-> $past(pop))
        else $error("issued rose without a pop in the cycle before");

    valid_after_issued: assert property (@(posedge clk) disable iff (!rst)
        issued |=> issue_valid)
        else $error("issue_valid did not follow issued");

    valid_needs_issued: assert property (@(posedge clk) disable iff (!rst)
        issue_valid |-> $past(issued))
        else $error("issue_valid rose without issued in the cycle before");

    // with the ROB full nothing new enters stage one, so stage two empties a cycle later
    drain_when_rob_full: assert property (@(posedge clk) disable iff (!rst)
        rob_full |=> !issued ##1 !issue_valid)
        else $error("an instruction kept issuing while rob_full was high");

endmodule

`default_nettype wire

//--- verif/instr_queue_checker.sv
`timescale 1ns/100ps
`default_nettype none

module instr_queue_checker (
    input  wire                         clk,
    input  wire                         rst,
    input  wire iq_types_pkg::opcode_t  op,
    input  wire iq_types_pkg::reg_idx_t rs1,
    input  wire iq_types_pkg::reg_idx_t rs2,
    input  wire iq_types_pkg::reg_idx_t rd,
    input  wire iq_types_pkg::imm_t     imm,
    input  wire                         has_imm,
    input  wire                         rob_full,
    input  wire                         iq_full,
    input  wire                         issued,
    input  wire                         issue_valid,
    input  wire iq_types_pkg::opcode_t  op_out,
    input  wire iq_types_pkg::reg_idx_t rs1_out,
    input  wire iq_types_pkg::reg_idx_t rs2_out,
    input  wire iq_types_pkg::reg_idx_t rd_out,
    input  wire iq_types_pkg::imm_t     imm_out,
    input  wire                         has_imm_out,
    input  wire iq_cfg_pkg::issue_tag_t issue_tag,
    output int                          error_count,
    output int                          issue_total,
    output int                          drop_total,
    output logic                        model_idle
);
    import iq_types_pkg::*;
    import iq_cfg_pkg::*;

    typedef struct packed {
        opcode_t  op;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        imm_t     imm;
        logic     has_imm;
    } entry_t;

    entry_t     fifo_model[$];
    entry_t     s1_entry;
    entry_t     s2_entry;
    logic       s1_valid_exp;
    logic       s2_valid_exp;
    logic       full_exp;
    issue_tag_t tag_exp;
    logic       started = 1'b0;

    initial begin
        error_count = 0;
        issue_total = 0;
        drop_total  = 0;
        model_idle  = 1'b0;
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        error_count++;
        $display("CHECK FAILED time=%0t signal=%s expected=%0h actual=%0h",
                 $time, name, exp, act);
    endtask

    // model steps on the same edge as the DUT, using only its own state
    always @(posedge clk) begin
        logic   do_push;
        logic   do_pop;
        entry_t incoming;
        if (!rst) begin
            fifo_model.delete();
            s1_valid_exp = 1'b0;
            s2_valid_exp = 1'b0;
            full_exp     = 1'b0;
            tag_exp      = '0;
            started      = 1'b1;
        end else begin
            incoming = '{op, rs1, rs2, rd, imm, has_imm};
            do_pop   = (fifo_model.size() != 0) && !rob_full;
            do_push  = (op != OP_BUBBLE) && !full_exp;
            if ((op != OP_BUBBLE) && full_exp) begin
                drop_total++;
            end
            if (s2_valid_exp) begin
                tag_exp = tag_exp + 1'b1;
                issue_total++;
            end
            s2_valid_exp = s1_valid_exp;
            s2_entry     = s1_entry;
            s1_valid_exp = do_pop;
            if (do_pop) begin
                s1_entry = fifo_model.pop_front();
            end
            if (do_push) begin
                fifo_model.push_back(incoming);
            end
            full_exp = (fifo_model.size() >= IQ_FULL_LEVEL);
        end
        model_idle = started && (fifo_model.size() == 0) && !s1_valid_exp && !s2_valid_exp;
    end

    // registered outputs settle after the rising edge, so compare mid cycle
    always @(negedge clk) begin
        if (started) begin
            if (iq_full !== full_exp) report_mismatch("iq_full", full_exp, iq_full);
            if (issued !== s1_valid_exp) report_mismatch("issued", s1_valid_exp, issued);
            if (issue_valid !== s2_valid_exp) begin
                report_mismatch("issue_valid", s2_valid_exp, issue_valid);
            end
            if (issue_tag !== tag_exp) report_mismatch("issue_tag", tag_exp, issue_tag);
            if (s2_valid_exp) begin
                if (op_out !== s2_entry.op) report_mismatch("op_out", s2_entry.op, op_out);
                if (rs1_out !== s2_entry.rs1) report_mismatch("rs1_out", s2_entry.rs1, rs1_out);
                if (rs2_out !== s2_entry.rs2) report_mismatch("rs2_out", s2_entry.rs2, rs2_out);
                if (rd_out !== s2_entry.rd) report_mismatch("rd_out", s2_entry.rd, rd_out);
                if (imm_out !== s2_entry.imm) report_mismatch("imm_out", s2_entry.imm, imm_out);
                if (has_imm_out !== s2_entry.has_imm) begin
                    report_mismatch("has_imm_out", s2_entry.has_imm, has_imm_out);
                end
            end else if (op_out !== OP_BUBBLE) begin
                report_mismatch("op_out", OP_BUBBLE, op_out);
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/instr_queue_tb.sv
`timescale 1ns/100ps
`default_nettype none

module instr_queue_tb;
    import iq_types_pkg::*;
    import iq_cfg_pkg::*;

    localparam int STIM_CYCLES  = 2000;
    localparam int DRAIN_CYCLES = 100;

    logic       clk;
    logic       rst;
    opcode_t    op;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    imm_t       imm;
    logic       has_imm;
    logic       rob_full;
    logic       iq_full;
    logic       issued;
    logic       issue_valid;
    opcode_t    op_out;
    reg_idx_t   rs1_out;
    reg_idx_t   rs2_out;
    reg_idx_t   rd_out;
    imm_t       imm_out;
    logic       has_imm_out;
    issue_tag_t issue_tag;

    int          error_count;
    int          issue_total;
    int          drop_total;
    logic        model_idle;
    int          tb_errors;
    int          burst_left;
    logic [31:0] lfsr;

    instr_queue instr_queue_i (
        .clk(clk), .rst(rst), .op(op), .rs1(rs1), .rs2(rs2), .rd(rd),
        .imm(imm), .has_imm(has_imm), .rob_full(rob_full), .iq_full(iq_full),
        .issued(issued), .issue_valid(issue_valid), .op_out(op_out),
        .rs1_out(rs1_out), .rs2_out(rs2_out), .rd_out(rd_out), .imm_out(imm_out),
        .has_imm_out(has_imm_out), .issue_tag(issue_tag)
    );

    instr_queue_checker checker_i (
        .clk(clk), .rst(rst), .op(op), .rs1(rs1), .rs2(rs2), .rd(rd),
        .imm(imm), .has_imm(has_imm), .rob_full(rob_full), .iq_full(iq_full),
        .issued(issued), .issue_valid(issue_valid), .op_out(op_out),
        .rs1_out(rs1_out), .rs2_out(rs2_out), .rd_out(rd_out), .imm_out(imm_out),
        .has_imm_out(has_imm_out), .issue_tag(issue_tag), .error_count(error_count),
        .issue_total(issue_total), .drop_total(drop_total), .model_idle(model_idle)
    );

    bind instr_queue instr_queue_assert instr_queue_assert_i (
        .clk(clk), .rst(rst), .rob_full(rob_full), .iq_full(iq_full), .push(push),
        .pop(pop), .issued(issued), .issue_valid(issue_valid)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] nxt;
        nxt = state >> 1;
        if (state[0]) begin
            nxt = nxt ^ 32'h80200003;
        end
        return nxt;
    endfunction

    task automatic take_bits(input int n, output logic [31:0] bits);
        int i;
        bits = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            bits = {bits[30:0], lfsr[0]};
        end
    endtask

    // instructions keep coming while full so that drops get exercised
    task automatic drive_random_cycle();
        logic [31:0] bits;
        take_bits(1, bits);
        if (bits[0]) begin
            take_bits(5, bits);
            op = opcode_t'(bits);
        end else begin
            op = OP_BUBBLE;
        end
        take_bits(5, bits);
        rs1 = reg_idx_t'(bits);
        take_bits(5, bits);
        rs2 = reg_idx_t'(bits);
        take_bits(5, bits);
        rd = reg_idx_t'(bits);
        take_bits(32, bits);
        imm = bits;
        take_bits(1, bits);
        has_imm = bits[0];
        // long high bursts on rob_full let the queue fill up
        if (burst_left > 0) begin
            rob_full = 1'b1;
            burst_left--;
        end else begin
            take_bits(4, bits);
            if (bits[3:0] == 4'd0) begin
                take_bits(4, bits);
                burst_left = 32 + int'(bits[3:0]);
                rob_full   = 1'b1;
            end else begin
                take_bits(2, bits);
                rob_full = (bits[1:0] == 2'd0);
            end
        end
    endtask

    initial begin
        int waited;
        clk        = 1'b0;
        rst        = 1'b0;
        op         = OP_BUBBLE;
        rs1        = '0;
        rs2        = '0;
        rd         = '0;
        imm        = '0;
        has_imm    = 1'b0;
        rob_full   = 1'b0;
        tb_errors  = 0;
        burst_left = 0;
        lfsr       = 32'h157b68f4;
        repeat (5) @(negedge clk);
        rst = 1'b1;
        repeat (STIM_CYCLES) begin
            @(negedge clk);
            drive_random_cycle();
        end
        @(negedge clk);
        op       = OP_BUBBLE;
        rob_full = 1'b0;
        waited   = 0;
        while (!model_idle && waited < DRAIN_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (!model_idle) begin
            tb_errors++;
            $display("timeout: the queue did not drain within %0d cycles", DRAIN_CYCLES);
        end
        if (issue_total == 0) begin
            tb_errors++;
            $display("no instruction was issued during the whole run");
        end
        if (drop_total == 0) begin
            tb_errors++;
            $display("the stimulus never offered an instruction to a full queue");
        end
        $display("check errors: %0d, testbench errors: %0d, issued: %0d, dropped: %0d",
                 error_count, tb_errors, issue_total, drop_total);
        if (error_count == 0 && tb_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/instr_queue.sv
`timescale 1ns/100ps
`default_nettype none

module instr_queue (
    input  wire                         clk,
    input  wire                         rst,
    input  wire iq_types_pkg::opcode_t  op,
    input  wire iq_types_pkg::reg_idx_t rs1,
    input  wire iq_types_pkg::reg_idx_t rs2,
    input  wire iq_types_pkg::reg_idx_t rd,
    input  wire iq_types_pkg::imm_t     imm,
    input  wire                         has_imm,
    input  wire                         rob_full,
    output logic                        iq_full,
    output logic                        issued,
    output logic                        issue_valid,
    output iq_types_pkg::opcode_t       op_out,
    output iq_types_pkg::reg_idx_t      rs1_out,
    output iq_types_pkg::reg_idx_t      rs2_out,
    output iq_types_pkg::reg_idx_t      rd_out,
    output iq_types_pkg::imm_t          imm_out,
    output logic                        has_imm_out,
    output iq_cfg_pkg::issue_tag_t      issue_tag
);
    import iq_cfg_pkg::*;

    logic    push;
    logic    pop;
    iq_ptr_t wr_ptr;
    iq_ptr_t rd_ptr;

    iq_entry_if wr_entry ();
    iq_entry_if rd_entry ();

    assign wr_entry.op      = op;
    assign wr_entry.rs1     = rs1;
    assign wr_entry.rs2     = rs2;
    assign wr_entry.rd      = rd;
    assign wr_entry.imm     = imm;
    assign wr_entry.has_imm = has_imm;

    iq_ctrl iq_ctrl_i (
        .clk      (clk),
        .rst      (rst),
        .op       (op),
        .rob_full (rob_full),
        .iq_full  (iq_full),
        .push     (push),
        .pop      (pop),
        .wr_ptr   (wr_ptr),
        .rd_ptr   (rd_ptr)
    );

    iq_entry_ram iq_entry_ram_i (
        .clk    (clk),
        .push   (push),
        .wr_ptr (wr_ptr),
        .pop    (pop),
        .rd_ptr (rd_ptr),
        .wr     (wr_entry.reader),
        .rd     (rd_entry.writer)
    );

    iq_issue_pipe iq_issue_pipe_i (
        .clk         (clk),
        .rst         (rst),
        .pop         (pop),
        .rd          (rd_entry.reader),
        .issued      (issued),
        .issue_valid (issue_valid),
        .op_out      (op_out),
        .rs1_out     (rs1_out),
        .rs2_out     (rs2_out),
        .rd_out      (rd_out),
        .imm_out     (imm_out),
        .has_imm_out (has_imm_out),
        .issue_tag   (issue_tag)
    );

endmodule

`default_nettype wire

//--- verilog/iq_cfg_pkg.sv
`default_nettype none

package iq_cfg_pkg;

    localparam int IQ_DEPTH    = 16;
    localparam int IQ_PTR_W    = $clog2(IQ_DEPTH);
    localparam int ISSUE_TAG_W = 4;

    typedef logic [IQ_PTR_W-1:0] iq_ptr_t;

    // one extra bit so a completely full buffer could still be counted
    typedef logic [IQ_PTR_W:0] iq_count_t;

    typedef logic [ISSUE_TAG_W-1:0] issue_tag_t;

    // one slot is kept free, so the queue reports full at depth minus one
    localparam iq_count_t IQ_FULL_LEVEL = iq_count_t'(IQ_DEPTH - 1);

endpackage

`default_nettype wire

//--- verilog/iq_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module iq_ctrl (
    input  wire                     clk,
    input  wire                     rst,
    input  wire iq_types_pkg::opcode_t op,
    input  wire                     rob_full,
    output logic                    iq_full,
    output logic                    push,
    output logic                    pop,
    output iq_cfg_pkg::iq_ptr_t     wr_ptr,
    output iq_cfg_pkg::iq_ptr_t     rd_ptr
);
    import iq_types_pkg::*;
    import iq_cfg_pkg::*;

    iq_ptr_t   head;
    iq_ptr_t   tail;
    iq_count_t count;
    iq_count_t count_next;

    // anything arriving while full is simply lost, decode is not stalled
    assign push = (op != OP_BUBBLE) && !iq_full;
    assign pop  = (count != '0) && !rob_full;

    assign wr_ptr = tail;
    assign rd_ptr = head;

    always_comb begin
        count_next = count;
        case ({push, pop})
            2'b10: begin
                count_next = count + iq_count_t'(1);
            end
            2'b01: begin
                count_next = count - iq_count_t'(1);
            end
            default: begin
                count_next = count;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            head    <= '0;
            tail    <= '0;
            count   <= '0;
            iq_full <= 1'b0;
        end else begin
            if (push) begin
                tail <= tail + iq_ptr_t'(1);
            end
            if (pop) begin
                head <= head + iq_ptr_t'(1);
            end
            count <= count_next;
            // looking at the next count keeps the flag aligned with the stored count
            iq_full <= (count_next >= IQ_FULL_LEVEL);
        end
    end

endmodule

`default_nettype wire

//--- verilog/iq_entry_if.sv
`timescale 1ns/100ps
`default_nettype none

interface iq_entry_if;
    import iq_types_pkg::*;

    opcode_t  op;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    imm_t     imm;
    logic     has_imm;

    modport writer (
        output op,
        output rs1,
        output rs2,
        output rd,
        output imm,
        output has_imm
    );

    modport reader (
        input op,
        input rs1,
        input rs2,
        input rd,
        input imm,
        input has_imm
    );

endinterface

`default_nettype wire

//--- verilog/iq_entry_ram.sv
`timescale 1ns/100ps
`default_nettype none

module iq_entry_ram (
    input  wire                 clk,
    input  wire                 push,
    input  wire iq_cfg_pkg::iq_ptr_t wr_ptr,
    input  wire                 pop,
    input  wire iq_cfg_pkg::iq_ptr_t rd_ptr,
    iq_entry_if.reader          wr,
    iq_entry_if.writer          rd
);
    import iq_types_pkg::*;
    import iq_cfg_pkg::*;

    opcode_t  op_mem      [IQ_DEPTH];
    reg_idx_t rs1_mem     [IQ_DEPTH];
    reg_idx_t rs2_mem     [IQ_DEPTH];
    reg_idx_t rd_mem      [IQ_DEPTH];
    imm_t     imm_mem     [IQ_DEPTH];
    logic     has_imm_mem [IQ_DEPTH];

    always_ff @(posedge clk) begin
        if (push) begin
            op_mem[wr_ptr]      <= wr.op;
            rs1_mem[wr_ptr]     <= wr.rs1;
            rs2_mem[wr_ptr]     <= wr.rs2;
            rd_mem[wr_ptr]      <= wr.rd;
            imm_mem[wr_ptr]     <= wr.imm;
            has_imm_mem[wr_ptr] <= wr.has_imm;
        end
    end

    // read register holds the popped entry until the next pop
    // head and tail never meet on a pop, so no write-through path is needed
    always_ff @(posedge clk) begin
        if (pop) begin
            rd.op      <= op_mem[rd_ptr];
            rd.rs1     <= rs1_mem[rd_ptr];
            rd.rs2     <= rs2_mem[rd_ptr];
            rd.rd      <= rd_mem[rd_ptr];
            rd.imm     <= imm_mem[rd_ptr];
            rd.has_imm <= has_imm_mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

//--- verilog/iq_issue_pipe.sv
`timescale 1ns/100ps
`default_nettype none

module iq_issue_pipe (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        pop,
    iq_entry_if.reader                 rd,
    output logic                       issued,
    output logic                       issue_valid,
    output iq_types_pkg::opcode_t      op_out,
    output iq_types_pkg::reg_idx_t     rs1_out,
    output iq_types_pkg::reg_idx_t     rs2_out,
    output iq_types_pkg::reg_idx_t     rd_out,
    output iq_types_pkg::imm_t         imm_out,
    output logic                       has_imm_out,
    output iq_cfg_pkg::issue_tag_t     issue_tag
);
    import iq_types_pkg::*;
    import iq_cfg_pkg::*;

    // stage one valid, doubles as the early warning to the ROB
    always_ff @(posedge clk) begin
        if (!rst) begin
            issued <= 1'b0;
        end else begin
            issued <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            issue_valid <= 1'b0;
            op_out      <= OP_BUBBLE;
            issue_tag   <= '0;
        end else begin
            issue_valid <= issued;
            op_out      <= issued ? rd.op : OP_BUBBLE;
            // tag moves on once the current instruction has been presented
            if (issue_valid) begin
                issue_tag <= issue_tag + issue_tag_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issued) begin
            rs1_out     <= rd.rs1;
            rs2_out     <= rd.rs2;
            rd_out      <= rd.rd;
            imm_out     <= rd.imm;
            has_imm_out <= rd.has_imm;
        end
    end

endmodule

`default_nettype wire

//--- verilog/iq_types_pkg.sv
`default_nettype none

package iq_types_pkg;

    localparam int OPCODE_W  = 5;
    localparam int REG_IDX_W = 5;
    localparam int IMM_W     = 32;

    typedef logic [OPCODE_W-1:0]  opcode_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [IMM_W-1:0]     imm_t;

    // decode sends the all-ones opcode when it has nothing to hand over
    localparam opcode_t OP_BUBBLE = '1;

endpackage

`default_nettype wire

//--- vlog.f
verilog/iq_types_pkg.sv
verilog/iq_cfg_pkg.sv
verilog/iq_entry_if.sv
verilog/iq_ctrl.sv
verilog/iq_entry_ram.sv
verilog/iq_issue_pipe.sv
verilog/instr_queue.sv
verif/instr_queue_assert.sv
verif/instr_queue_checker.sv
verif/instr_queue_tb.sv
